//--- common/blur_pkg.sv
// Blur kernel definitions
// Pixel and sum widths plus the 1 2 1 / 2 4 2 / 1 2 1 weights of the 3x3 Gaussian blur
package blur_pkg;

    typedef logic [7:0]  pixel_t;
    typedef logic [11:0] sum_t;     // Holds 16 x 255

    // Division by 16 after the weighted sum
    localparam int kernel_shift = 4;

    // Weight of one window tap, row and column counted from the top left
    function automatic sum_t kernel_weight(input int row, input int col);
        sum_t weight;
        weight = sum_t'(1);
        if (row == 1) begin
            weight = weight << 1;
        end
        if (col == 1) begin
            weight = weight << 1;
        end
        return weight;
    endfunction

endpackage

//--- common/eq_pkg.sv
// Equivalence harness definitions
// Phase encoding and counter widths shared by the control block and the checker
package eq_pkg;

    typedef enum logic [1:0] {
        phase_run,
        phase_settle,
        phase_done
    } phase_t;

    // Cycles spent until both models complete
    typedef logic [15:0] cycle_t;

    // Output pairs that differ
    typedef logic [15:0] err_count_t;

endpackage

//--- blur_spec/blur_spec.sv
`timescale 1ns/1ps
// High-level blur model
// Keeps the last three rows in a store addressed by coordinates and blurs each full window
module blur_spec #(
    parameter int img_width  = 8,
    parameter int img_height = 6
) (
    input  logic             clk,
    input  logic             rst_init,
    input  blur_pkg::pixel_t in_data,
    input  logic             in_valid,
    output logic             in_ready,
    output blur_pkg::pixel_t out_data,
    output logic             out_valid,
    input  logic             out_ready,
    output logic             complete
);
    import blur_pkg::*;

    localparam int x_w       = $clog2(img_width);
    localparam int y_w       = $clog2(img_height);
    localparam int out_total = (img_width - 2) * (img_height - 2);
    localparam int cnt_w     = $clog2(out_total + 1);

    typedef logic [x_w-1:0] col_t;
    typedef logic [y_w-1:0] row_t;

    pixel_t           store [3][img_width];
    col_t             x;
    row_t             y;
    logic [1:0]       row_ptr;      // Store row of y, which is y modulo three
    logic [1:0]       row_idx [3];  // Store rows of y-2, y-1 and y
    logic [cnt_w-1:0] out_cnt;
    logic             in_fire;
    logic             out_fire;
    logic             window_full;
    sum_t             window_sum;

    assign in_ready    = ~out_valid & ~complete;
    assign in_fire     = in_valid & in_ready;
    assign out_fire    = out_valid & out_ready;
    assign window_full = (x >= col_t'(2)) && (y >= row_t'(2));

    assign row_idx[0] = (row_ptr == 2'd2) ? 2'd0 : row_ptr + 2'd1;
    assign row_idx[1] = (row_ptr == 2'd0) ? 2'd2 : row_ptr - 2'd1;
    assign row_idx[2] = row_ptr;

    // ##########################################################
    // Window read by coordinate

    always_comb begin
        pixel_t tap;
        col_t   col;
        window_sum = '0;
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < 3; c++) begin
                col = x - col_t'(2 - c);
                if (r == 2 && c == 2) begin
                    tap = in_data;      // Newest pixel is not in the store yet
                end else begin
                    tap = store[row_idx[r]][col];
                end
                window_sum = window_sum + kernel_weight(r, c) * sum_t'(tap);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            store[row_ptr][x] <= in_data;
        end
        if (in_fire && window_full) begin
            out_data <= pixel_t'(window_sum >> kernel_shift);
        end
    end

    // ##########################################################
    // Coordinates and output count

    always_ff @(posedge clk) begin
        if (rst_init) begin
            x         <= '0;
            y         <= '0;
            row_ptr   <= '0;
            out_valid <= 1'b0;
            out_cnt   <= '0;
            complete  <= 1'b0;
        end else begin
            if (in_fire) begin
                if (x == col_t'(img_width - 1)) begin
                    x <= '0;
                    if (y == row_t'(img_height - 1)) begin
                        y       <= '0;
                        row_ptr <= 2'd0;
                    end else begin
                        y       <= y + 1'b1;
                        row_ptr <= (row_ptr == 2'd2) ? 2'd0 : row_ptr + 2'd1;
                    end
                end else begin
                    x <= x + 1'b1;
                end
            end
            if (in_fire && window_full) begin
                out_valid <= 1'b1;
            end else if (out_fire) begin
                out_valid <= 1'b0;
                out_cnt   <= out_cnt + 1'b1;
                if (out_cnt == cnt_w'(out_total - 1)) begin
                    complete <= 1'b1;   // Last output of the frame has left
                end
            end
        end
    end

endmodule

//--- blur_impl/stream_fifo.sv
`timescale 1ns/1ps
// Output queue of the detailed blur
// Two entries with a level count that the model uses to hold back its input
module stream_fifo (
    input  logic             clk,
    input  logic             rst_init,
    input  logic             push,
    input  blur_pkg::pixel_t push_data,
    output logic             full,
    input  logic             pop,
    output blur_pkg::pixel_t pop_data,
    output logic             empty,
    output logic [1:0]       level
);
    import blur_pkg::*;

    pixel_t mem [2];
    logic   wr_ptr;
    logic   rd_ptr;
    logic   do_push;
    logic   do_pop;

    assign full     = (level == 2'd2);
    assign empty    = (level == 2'd0);
    assign do_push  = push & ~full;     // A push into a full queue is dropped
    assign do_pop   = pop & ~empty;
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_init) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            level  <= 2'd0;
        end else begin
            if (do_push) wr_ptr <= ~wr_ptr;
            if (do_pop) rd_ptr <= ~rd_ptr;
            if (do_push && !do_pop) begin
                level <= level + 2'd1;
            end else if (do_pop && !do_push) begin
                level <= level - 2'd1;
            end
        end
    end

endmodule

//--- blur_impl/blur_impl.sv
`timescale 1ns/1ps
// Detailed blur model
// Line buffers feed a 3x3 shift window, a two-stage adder and a small output queue
module blur_impl #(
    parameter int img_width  = 8,
    parameter int img_height = 6
) (
    input  logic             clk,
    input  logic             rst_init,
    input  blur_pkg::pixel_t in_data,
    input  logic             in_valid,
    output logic             in_ready,
    output blur_pkg::pixel_t out_data,
    output logic             out_valid,
    input  logic             out_ready,
    output logic             complete
);
    import blur_pkg::*;

    localparam int x_w       = $clog2(img_width);
    localparam int y_w       = $clog2(img_height);
    localparam int out_total = (img_width - 2) * (img_height - 2);
    localparam int cnt_w     = $clog2(out_total + 1);

    pixel_t           line_prev [img_width];    // Row y-1
    pixel_t           line_old  [img_width];    // Row y-2
    pixel_t           win [3][3];               // Row 0 oldest, column 2 newest
    sum_t             row_sum [3];
    sum_t             total;
    logic [x_w-1:0]   x;
    logic [y_w-1:0]   y;
    logic             win_valid;
    logic             sum_valid;
    logic [cnt_w-1:0] out_cnt;
    logic             in_fire;
    logic             out_fire;
    logic             fifo_full;
    logic             fifo_empty;
    logic [1:0]       fifo_level;
    logic [2:0]       pending;

    // Queued results plus those still in the adder must leave room for one more
    assign pending  = {1'b0, fifo_level} + {2'b00, win_valid} + {2'b00, sum_valid};
    assign in_ready = ~complete & ~fifo_full & (pending < 3'd2);
    assign in_fire  = in_valid & in_ready;

    assign out_valid = ~fifo_empty;
    assign out_fire  = out_valid & out_ready;

    // ##########################################################
    // Line buffers, shift window and adder datapath

    always_ff @(posedge clk) begin
        if (in_fire) begin
            line_old[x]  <= line_prev[x];
            line_prev[x] <= in_data;
            for (int r = 0; r < 3; r++) begin
                win[r][0] <= win[r][1];
                win[r][1] <= win[r][2];
            end
            win[0][2] <= line_old[x];
            win[1][2] <= line_prev[x];
            win[2][2] <= in_data;
        end
        for (int r = 0; r < 3; r++) begin
            row_sum[r] <= sum_t'(win[r][0]) + (sum_t'(win[r][1]) << 1) + sum_t'(win[r][2]);
        end
    end

    // Second adder stage goes straight into the queue
    assign total = row_sum[0] + (row_sum[1] << 1) + row_sum[2];

    stream_fifo u_fifo (
        .clk(clk), .rst_init(rst_init),
        .push(sum_valid), .push_data(pixel_t'(total >> kernel_shift)), .full(fifo_full),
        .pop(out_fire), .pop_data(out_data), .empty(fifo_empty), .level(fifo_level)
    );

    // ##########################################################
    // Position tracker and output count

    always_ff @(posedge clk) begin
        if (rst_init) begin
            x         <= '0;
            y         <= '0;
            win_valid <= 1'b0;
            sum_valid <= 1'b0;
            out_cnt   <= '0;
            complete  <= 1'b0;
        end else begin
            win_valid <= in_fire && (x >= x_w'(2)) && (y >= y_w'(2));
            sum_valid <= win_valid;
            if (in_fire) begin
                if (x == x_w'(img_width - 1)) begin
                    x <= '0;
                    y <= (y == y_w'(img_height - 1)) ? '0 : y + 1'b1;
                end else begin
                    x <= x + 1'b1;
                end
            end
            if (out_fire) begin
                out_cnt <= out_cnt + 1'b1;
                if (out_cnt == cnt_w'(out_total - 1)) begin
                    complete <= 1'b1;
                end
            end
        end
    end

endmodule

//--- hw/eq_control.sv
`timescale 1ns/1ps
// Equivalence control
// Admits input to both blur models at once, releases their outputs in lockstep, tracks the run
module eq_control #(
    parameter int img_width  = 8,
    parameter int img_height = 6
) (
    input  logic           clk,
    input  logic           rst_init,
    input  logic           in_valid,
    output logic           in_ready,
    input  logic           spec_in_ready,
    input  logic           impl_in_ready,
    output logic           spec_in_valid,
    output logic           impl_in_valid,
    input  logic           spec_out_valid,
    input  logic           impl_out_valid,
    input  logic           out_ready,
    output logic           out_valid,
    output logic           spec_out_ready,
    output logic           impl_out_ready,
    output logic           pair_fire,
    input  logic           spec_complete,
    input  logic           impl_complete,
    output eq_pkg::cycle_t cycle_count,
    output eq_pkg::phase_t phase,
    output logic           done
);
    import eq_pkg::*;

    localparam int frame_pixels = img_width * img_height;
    localparam int admit_w      = $clog2(frame_pixels + 1);

    logic [admit_w-1:0] admitted;       // Pixels taken from the input stream so far
    logic               in_fire;
    logic               both_complete;
    phase_t             phase_next;

    // ##########################################################
    // Stream synchronization

    // A pixel goes to both models or to neither, one frame at most
    assign in_ready = spec_in_ready & impl_in_ready & (admitted != admit_w'(frame_pixels));
    assign in_fire  = in_valid & in_ready;

    assign spec_in_valid = in_fire;
    assign impl_in_valid = in_fire;

    assign out_valid      = spec_out_valid & impl_out_valid;
    assign pair_fire      = out_valid & out_ready;
    assign spec_out_ready = pair_fire;
    assign impl_out_ready = pair_fire;

    // ##########################################################
    // Run tracking

    assign both_complete = spec_complete & impl_complete;
    assign done          = (phase == phase_done);

    always_comb begin
        phase_next = phase;
        case (phase)
            phase_run: begin
                if (both_complete) begin
                    phase_next = phase_settle;
                end
            end
            default: phase_next = phase_done;   // Settle lasts a single cycle
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_init) begin
            admitted    <= '0;
            cycle_count <= '0;
            phase       <= phase_run;
        end else begin
            if (in_fire) begin
                admitted <= admitted + 1'b1;
            end
            if (!both_complete) begin
                cycle_count <= cycle_count + 1'b1;   // Frozen once both are complete
            end
            phase <= phase_next;
        end
    end

endmodule

//--- hw/output_checker.sv
`timescale 1ns/1ps
// Output pair checker
// Compares each released pair of model outputs and counts the pairs that differ
module output_checker (
    input  logic               clk,
    input  logic               rst_init,
    input  logic               pair_fire,
    input  blur_pkg::pixel_t   spec_data,
    input  blur_pkg::pixel_t   impl_data,
    output eq_pkg::err_count_t mismatch_count,
    output eq_pkg::cycle_t     first_bad_index
);
    import eq_pkg::*;

    cycle_t pair_index;     // Pairs compared so far
    logic   differ;

    assign differ = pair_fire && (spec_data != impl_data);

    always_ff @(posedge clk) begin
        if (rst_init) begin
            pair_index      <= '0;
            mismatch_count  <= '0;
            first_bad_index <= '1;      // All ones until a pair differs
        end else begin
            if (pair_fire) begin
                pair_index <= pair_index + 1'b1;
            end
            if (differ) begin
                mismatch_count <= mismatch_count + 1'b1;
                // Only the first differing pair is recorded
                if (mismatch_count == '0) begin
                    first_bad_index <= pair_index;
                end
            end
        end
    end

endmodule

//--- hw/eq_top.sv
`timescale 1ns/1ps
// Equivalence harness top
// Runs the high-level and the detailed blur side by side under one control block
module eq_top #(
    parameter int img_width  = 8,
    parameter int img_height = 6
) (
    input  logic               clk,
    input  logic               rst_init,
    input  blur_pkg::pixel_t   in_data,
    input  logic               in_valid,
    output logic               in_ready,
    output blur_pkg::pixel_t   out_data,
    output logic               out_valid,
    input  logic               out_ready,
    output logic               done,
    output eq_pkg::cycle_t     cycle_count,
    output eq_pkg::err_count_t mismatch_count
);
    import blur_pkg::*;
    import eq_pkg::*;

    logic   spec_in_valid;
    logic   spec_in_ready;
    logic   spec_out_valid;
    logic   spec_out_ready;
    logic   spec_complete;
    logic   impl_in_valid;
    logic   impl_in_ready;
    logic   impl_out_valid;
    logic   impl_out_ready;
    logic   impl_complete;
    logic   pair_fire;
    pixel_t impl_out_data;
    phase_t phase;
    cycle_t first_bad_index;    // Kept for debug

    eq_control #(.img_width(img_width), .img_height(img_height)) u_control (
        .clk(clk), .rst_init(rst_init),
        .in_valid(in_valid), .in_ready(in_ready),
        .spec_in_ready(spec_in_ready), .impl_in_ready(impl_in_ready),
        .spec_in_valid(spec_in_valid), .impl_in_valid(impl_in_valid),
        .spec_out_valid(spec_out_valid), .impl_out_valid(impl_out_valid),
        .out_ready(out_ready), .out_valid(out_valid),
        .spec_out_ready(spec_out_ready), .impl_out_ready(impl_out_ready),
        .pair_fire(pair_fire),
        .spec_complete(spec_complete), .impl_complete(impl_complete),
        .cycle_count(cycle_count), .phase(phase), .done(done)
    );

    // The released stream carries the high-level model's result
    blur_spec #(.img_width(img_width), .img_height(img_height)) u_spec (
        .clk(clk), .rst_init(rst_init),
        .in_data(in_data), .in_valid(spec_in_valid), .in_ready(spec_in_ready),
        .out_data(out_data), .out_valid(spec_out_valid), .out_ready(spec_out_ready),
        .complete(spec_complete)
    );

    blur_impl #(.img_width(img_width), .img_height(img_height)) u_impl (
        .clk(clk), .rst_init(rst_init),
        .in_data(in_data), .in_valid(impl_in_valid), .in_ready(impl_in_ready),
        .out_data(impl_out_data), .out_valid(impl_out_valid), .out_ready(impl_out_ready),
        .complete(impl_complete)
    );

    output_checker u_checker (
        .clk(clk), .rst_init(rst_init), .pair_fire(pair_fire),
        .spec_data(out_data), .impl_data(impl_out_data),
        .mismatch_count(mismatch_count), .first_bad_index(first_bad_index)
    );

endmodule

//--- bench/eq_assert.sv
`timescale 1ns/1ps
// Harness assertions
// Watch the output lockstep and the end of the run on the harness top
module eq_assert (
    input logic           clk,
    input logic           rst_init,
    input logic           spec_out_valid,
    input logic           impl_out_valid,
    input logic           out_valid,
    input logic           out_ready,
    input eq_pkg::phase_t phase,
    input logic           done,
    input eq_pkg::cycle_t cycle_count
);
    import eq_pkg::*;

    int failures = 0;       // Failed assertion attempts so far

    // A model result waits until the pair is released together
    spec_result_held: assert property (@(posedge clk) disable iff (rst_init)
        (spec_out_valid && !(out_valid && out_ready)) |=> spec_out_valid)
    else begin
        failures++;
        $error("spec result dropped before the pair was released");
    end

    impl_result_held: assert property (@(posedge clk) disable iff (rst_init)
        (impl_out_valid && !(out_valid && out_ready)) |=> impl_out_valid)
    else begin
        failures++;
        $error("impl result dropped before the pair was released");
    end

    done_phase_held: assert property (@(posedge clk) disable iff (rst_init)
        (phase == phase_done) |=> (phase == phase_done))
    else begin
        failures++;
        $error("phase left phase_done without a reset");
    end

    count_frozen: assert property (@(posedge clk) disable iff (rst_init)
        done |=> $stable(cycle_count))
    else begin
        failures++;
        $error("cycle_count moved while done was high");
    end

endmodule

//--- bench/eq_tb.sv
`timescale 1ns/1ps
// Equivalence harness testbench
// Streams random frames through both blur models and checks every released pixel
module eq_tb #(
    parameter int img_width  = 8,
    parameter int img_height = 6,
    parameter int seed       = 24
);
    import blur_pkg::*;
    import eq_pkg::*;

    localparam int frame_pixels   = img_width * img_height;
    localparam int out_total      = (img_width - 2) * (img_height - 2);
    localparam int timeout_cycles = 8 * frame_pixels + 300;

    logic       clk;
    logic       rst_init;
    pixel_t     in_data;
    logic       in_valid;
    logic       in_ready;
    pixel_t     out_data;
    logic       out_valid;
    logic       out_ready;
    logic       done;
    cycle_t     cycle_count;
    err_count_t mismatch_count;

    pixel_t frame [frame_pixels];
    logic   stall_pat [256];        // Random out_ready pattern, replayed by cycle
    logic   stall_mode = 1'b0;
    int     cycles = 0;
    int     out_idx = 0;            // Outputs seen since the last reset
    int     stall_cycles = 0;
    int     errors = 0;
    int     tests_passed = 0;
    int     tests_failed = 0;

    eq_top #(.img_width(img_width), .img_height(img_height)) uut (
        .clk(clk), .rst_init(rst_init),
        .in_data(in_data), .in_valid(in_valid), .in_ready(in_ready),
        .out_data(out_data), .out_valid(out_valid), .out_ready(out_ready),
        .done(done), .cycle_count(cycle_count), .mismatch_count(mismatch_count)
    );

    bind eq_top eq_assert u_assert (
        .clk(clk), .rst_init(rst_init),
        .spec_out_valid(spec_out_valid), .impl_out_valid(impl_out_valid),
        .out_valid(out_valid), .out_ready(out_ready),
        .phase(phase), .done(done), .cycle_count(cycle_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == timeout_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        out_ready = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            out_ready = stall_mode ? stall_pat[cycles % 256] : 1'b1;
        end
    end

    // ##########################################################
    // Reference model and reporting

    // Weighted 3x3 sum around the centre pixel, divided by 16 with truncation
    function automatic pixel_t blur_ref(input int cx, input int cy);
        int sum;
        int weight;
        sum = 0;
        for (int dy = -1; dy <= 1; dy++) begin
            for (int dx = -1; dx <= 1; dx++) begin
                weight = (dx == 0 ? 2 : 1) * (dy == 0 ? 2 : 1);
                sum += weight * int'(frame[(cy + dy) * img_width + cx + dx]);
            end
        end
        return pixel_t'(sum / 16);
    endfunction

    task automatic report_mismatch(input string name, input int got, input int exp);
        $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
        errors++;
    endtask

    task automatic report_failure(input string what);
        $display("error at %0t: %s", $time, what);
        errors++;
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    // Every released pair is checked in raster order
    always @(negedge clk) begin : compare
        pixel_t expected;
        if (rst_init) begin
            out_idx = 0;
        end else begin
            if (out_valid && !out_ready) begin
                stall_cycles++;
                if (in_ready) begin
                    report_failure("in_ready high while an output pair is stalled");
                end
            end
            if (out_valid && out_ready) begin
                if (out_idx >= out_total) begin
                    report_failure("an output arrived beyond the end of the frame");
                end else begin
                    expected = blur_ref(out_idx % (img_width - 2) + 1,
                                        out_idx / (img_width - 2) + 1);
                    if (out_data != expected) begin
                        report_mismatch("out_data", int'(out_data), int'(expected));
                    end
                end
                if (mismatch_count != '0) begin
                    report_mismatch("mismatch_count", int'(mismatch_count), 0);
                end
                out_idx++;
            end
        end
    end

    // ##########################################################
    // Stimulus tasks

    task automatic apply_reset();
        @(posedge clk);
        #1;
        rst_init = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        rst_init = 1'b0;
    endtask

    task automatic check_reset_state();
        @(negedge clk);
        if (!in_ready) report_failure("in_ready low after reset");
        if (out_valid) report_failure("out_valid high after reset");
        if (done) report_failure("done high after reset");
        if (cycle_count != '0) report_mismatch("cycle_count", int'(cycle_count), 0);
        if (mismatch_count != '0) report_mismatch("mismatch_count", int'(mismatch_count), 0);
        @(posedge clk);
        #1;
    endtask

    task automatic fill_frame();
        for (int i = 0; i < frame_pixels; i++) begin
            frame[i] = pixel_t'($urandom);
        end
    endtask

    task automatic send_pixels(input int count);
        int   sent;
        logic taken;
        sent = 0;
        while (sent < count) begin
            in_valid = 1'b1;
            in_data  = frame[sent];
            @(negedge clk);
            taken = in_ready;       // Transfer happens on the next rising edge
            @(posedge clk);
            #1;
            if (taken) begin
                sent++;
            end
        end
        in_valid = 1'b0;
    endtask

    task automatic check_completion();
        cycle_t final_count;
        while (!done) begin
            @(negedge clk);
        end
        if (out_idx != out_total) report_mismatch("output count", out_idx, out_total);
        if (int'(cycle_count) < frame_pixels) report_failure("cycle_count below the frame size");
        final_count = cycle_count;
        repeat (10) begin
            @(negedge clk);
            if (!done) report_failure("done fell before a reset");
            if (cycle_count != final_count) begin
                report_mismatch("cycle_count", int'(cycle_count), int'(final_count));
            end
        end
        if (out_idx != out_total) report_failure("extra outputs arrived after done");
        if (mismatch_count != '0) report_mismatch("mismatch_count", int'(mismatch_count), 0);
        // No pair differed, so no index was recorded
        if (uut.first_bad_index != '1) begin
            report_mismatch("first_bad_index", int'(uut.first_bad_index),
                            int'(cycle_t'('1)));
        end
    endtask

    task automatic run_frame();
        fill_frame();
        send_pixels(frame_pixels);
        check_completion();
    endtask

    // ##########################################################
    // Test sequence

    initial begin
        int mark;
        rst_init = 1'b1;
        in_valid = 1'b0;
        in_data  = '0;
        void'($urandom(seed));
        for (int i = 0; i < 256; i++) begin
            stall_pat[i] = 1'($urandom % 2);
        end

        mark = errors;
        apply_reset();
        check_reset_state();
        run_frame();
        finish_test("plain frame", mark);

        mark = errors;
        stall_mode = 1'b1;
        apply_reset();
        check_reset_state();
        stall_cycles = 0;
        run_frame();
        if (stall_cycles == 0) report_failure("no output stall was exercised");
        stall_mode = 1'b0;
        finish_test("stalled output", mark);

        mark = errors;
        apply_reset();
        check_reset_state();
        fill_frame();
        send_pixels(frame_pixels / 2);
        apply_reset();              // Aborts the frame half way
        check_reset_state();
        run_frame();
        finish_test("reset mid frame", mark);

        errors += uut.u_assert.failures;
        $display("tests passed: %0d, failed: %0d, assertion failures: %0d",
                 tests_passed, tests_failed, uut.u_assert.failures);
        if (tests_failed == 0 && errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- eq_blur.f
common/blur_pkg.sv
common/eq_pkg.sv
blur_spec/blur_spec.sv
blur_impl/stream_fifo.sv
blur_impl/blur_impl.sv
hw/eq_control.sv
hw/output_checker.sv
hw/eq_top.sv
bench/eq_assert.sv
bench/eq_tb.sv

//--- Makefile
# Verilator build for the blur equivalence harness

VERILATOR ?= verilator
TOP       ?= eq_tb
FILELIST  ?= eq_blur.f
BUILD_DIR ?= obj_dir
WIDTH     ?= 8
HEIGHT    ?= 6
SEED      ?= 24
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
RUN_ARGS  ?= +verilator+error+limit+1000
PARAMS    = -Gimg_width=$(WIDTH) -Gimg_height=$(HEIGHT) -Gseed=$(SEED)

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) $(PARAMS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) $(PARAMS) --top-module $(TOP) -Mdir $(BUILD_DIR) \
		-f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(BUILD_DIR)
